//--- cpuCore.f
source/corePkg.sv
source/regFile.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardUnit.sv
source/cpuCore.sv
test/coreChecker.sv
test/coreProps.sv
test/tbCore.sv

//--- Makefile
.PHONY: simulate clean

simulate:
	verilator --binary --assert --top-module tbCore -f cpuCore.f -o simCore
	./obj_dir/simCore | awk '{ print } /^>>> PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- test/tbCore.sv
module tbCore;
    import corePkg::*;

    localparam int romWords      = 256;
    localparam int progWords     = 200;
    localparam int endIndex      = progWords - 2;  // j to itself, then its delay slot
    localparam int driveDelay    = 2;
    localparam int timeoutCycles = progWords * (4 + 3 + 2) + 100;

    logic       clk = 1'b0;
    logic       rstN = 1'b0;
    word_t      instAddr;
    word_t      instData;
    logic       dataCyc;
    logic       dataStb;
    logic       dataWe;
    word_t      dataAdr;
    word_t      dataDatW;
    logic [3:0] dataSel;
    word_t      dataDatR = '0;
    logic       dataAck = 1'b0;
    word_t      debugWbPc;
    logic [3:0] debugWbRfWen;
    regAddr_t   debugWbRfWnum;
    word_t      debugWbRfWdata;

    word_t       rom [romWords];
    word_t       dataMem [64];
    logic [15:0] lfsr = 16'd97;
    logic        pending = 1'b0;
    int          waitLeft = 0;
    logic        done;
    int          mismatches;
    int          extras;

    cpuCore #(.resetPc(32'h0000_0000)) i_dut (.*);

    coreChecker #(.romWords(romWords), .endIndex(endIndex)) i_checker (.*);

    always #10 clk = ~clk;

    assign instData = rom[instAddr[9:2]];  // same-cycle fetch

    // galois lfsr, one step per bit
    function automatic logic [15:0] nextBits(int count);
        logic [15:0] value;
        logic        outBit;
        int          n;
        value = '0;
        for (n = 0; n < count; n++) begin
            outBit = lfsr[0];
            lfsr   = {1'b0, lfsr[15:1]} ^ (outBit ? 16'hb400 : 16'h0000);
            value  = {value[14:0], outBit};
        end
        return value;
    endfunction

    function automatic regAddr_t pickReg();
        return regAddr_t'(nextBits(3));  // r0 to r7
    endfunction

    function automatic word_t rType(logic [5:0] fn, regAddr_t rd, regAddr_t rs, regAddr_t rt);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t iType(logic [5:0] op, regAddr_t rt, regAddr_t rs,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic buildProgram();
        int          i;
        int          kind;
        int          skip;
        logic        inSlot;
        regAddr_t    rd;
        regAddr_t    rs;
        regAddr_t    rt;
        logic [15:0] imm;
        logic [15:0] offset;
        for (i = 0; i < romWords; i++) begin
            rom[i] = nopWord;
        end
        for (i = 1; i < 8; i++) begin
            rom[i - 1] = iType(opAddiu, regAddr_t'(i), 5'd0, nextBits(16));
        end
        inSlot = 1'b0;
        for (i = 7; i < endIndex; i++) begin
            kind   = int'(nextBits(4));
            rd     = pickReg();
            rs     = pickReg();
            rt     = pickReg();
            imm    = nextBits(16);
            offset = nextBits(6) << 2;
            skip   = int'(nextBits(3)) + 1;
            if (kind >= 13 && (inSlot || i > endIndex - 3)) begin
                kind = 6;  // no branch in a delay slot or near the end
            end
            if (i + 1 + skip > endIndex) begin
                skip = endIndex - 1 - i;
            end
            case (kind)
                0:       rom[i] = rType(fnAddu, rd, rs, rt);
                1:       rom[i] = rType(fnSubu, rd, rs, rt);
                2:       rom[i] = rType(fnAnd, rd, rs, rt);
                3:       rom[i] = rType(fnOr, rd, rs, rt);
                4:       rom[i] = rType(fnXor, rd, rs, rt);
                5:       rom[i] = rType(fnSlt, rd, rs, rt);
                6, 7:    rom[i] = iType(opAddiu, rt, rs, imm);
                8:       rom[i] = iType(opOri, rt, rs, imm);
                9:       rom[i] = iType(opLui, rt, 5'd0, imm);
                10, 11:  rom[i] = iType(opLw, rt, 5'd0, offset);
                12:      rom[i] = iType(opSw, rt, 5'd0, offset);
                13:      rom[i] = iType(opBeq, rt, rs, 16'(skip));
                14:      rom[i] = iType(opBne, rt, rs, 16'(skip));
                default: rom[i] = {opJ, 26'(i + 1 + skip)};
            endcase
            inSlot = kind >= 13;
        end
        rom[endIndex] = {opJ, 26'(endIndex)};
    endtask

    task automatic serveAccess();
        if (dataWe) begin
            dataMem[dataAdr[7:2]] = dataDatW;
        end else begin
            dataDatR = dataMem[dataAdr[7:2]];
        end
        dataAck = 1'b1;
    endtask

    // wishbone slave with 0 to 3 wait cycles
    always @(posedge clk) begin
        #(driveDelay);
        if (dataAck) begin
            dataAck = 1'b0;  // transfer ended at this edge
            pending = 1'b0;
        end
        if (rstN && dataCyc && dataStb && !pending) begin
            pending  = 1'b1;
            waitLeft = int'(nextBits(2));
        end
        if (pending) begin
            if (waitLeft == 0) begin
                serveAccess();
            end else begin
                waitLeft--;
            end
        end
    end

    initial begin
        int i;
        buildProgram();
        for (i = 0; i < 64; i++) begin
            dataMem[i] = word_t'(i) * 32'h0101_0101;
        end
        repeat (8) @(posedge clk);
        #(driveDelay) rstN = 1'b1;
        wait (done);
        repeat (20) @(posedge clk);  // late extra writes still show up
        $display("errors: %0d mismatched, %0d unexpected", mismatches, extras);
        if (mismatches == 0 && extras == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("timeout: program did not retire all its writes in %0d cycles", timeoutCycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- test/coreProps.sv
module coreProps (
    input logic              clk,
    input logic              rstN,
    input logic              dataCyc,
    input logic              dataStb,
    input logic              dataWe,
    input logic              dataAck,
    input corePkg::word_t    dataAdr,
    input logic [3:0]        debugWbRfWen,
    input corePkg::regAddr_t debugWbRfWnum
);

    cycMatchesStb: assert property (@(posedge clk) disable iff (!rstN) dataCyc == dataStb)
        else $error("dataCyc and dataStb differ");

    // request held until ack
    requestStable: assert property (@(posedge clk) disable iff (!rstN)
        dataStb && !dataAck |=> $stable(dataAdr) && $stable(dataWe))
        else $error("dataAdr or dataWe changed while waiting for ack");

    noWriteToZero: assert property (@(posedge clk) disable iff (!rstN)
        debugWbRfWen != 4'h0 |-> debugWbRfWnum != '0)
        else $error("debug write enable high for r0");

    quietAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> !dataCyc && debugWbRfWen == 4'h0)
        else $error("bus or debug port active right after reset");

endmodule

bind cpuCore coreProps i_props (.*);

//--- test/coreChecker.sv
module coreChecker #(
    parameter int romWords = 256,
    parameter int endIndex = 198
) (
    input  logic              clk,
    input  logic              rstN,
    input  corePkg::word_t    rom [romWords],
    input  logic              dataCyc,
    input  logic [3:0]        dataSel,
    input  corePkg::word_t    debugWbPc,
    input  logic [3:0]        debugWbRfWen,
    input  corePkg::regAddr_t debugWbRfWnum,
    input  corePkg::word_t    debugWbRfWdata,
    output logic              done,
    output int                mismatches,
    output int                extras
);
    import corePkg::*;

    word_t    expPc [$];
    regAddr_t expNum [$];
    word_t    expData [$];
    logic     built;

    // architectural run with delay slots, one entry per register write
    task automatic buildModel();
        word_t    regs [32];
        word_t    dmem [64];
        word_t    pc;
        word_t    nextPc;
        word_t    target;
        word_t    instr;
        word_t    a;
        word_t    b;
        word_t    imm;
        word_t    addr;
        word_t    result;
        regAddr_t dst;
        logic     wen;
        int       i;
        int       steps;
        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (i = 0; i < 64; i++) begin
            dmem[i] = word_t'(i) * 32'h0101_0101;
        end
        pc     = '0;
        nextPc = 32'd4;
        steps  = 0;
        while (pc != word_t'(endIndex * 4) && steps < 4 * romWords) begin
            instr  = rom[pc[9:2]];
            a      = regs[instr[25:21]];
            b      = regs[instr[20:16]];
            imm    = {{16{instr[15]}}, instr[15:0]};
            addr   = a + imm;
            target = nextPc + 32'd4;
            dst    = instr[20:16];
            wen    = 1'b1;
            result = '0;
            case (instr[31:26])
                opSpecial: begin
                    dst = instr[15:11];
                    case (instr[5:0])
                        fnAddu:  result = a + b;
                        fnSubu:  result = a - b;
                        fnAnd:   result = a & b;
                        fnOr:    result = a | b;
                        fnXor:   result = a ^ b;
                        fnSlt:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wen = 1'b0;
                    endcase
                end
                opAddiu: result = a + imm;
                opOri:   result = a | {16'h0000, instr[15:0]};
                opLui:   result = {instr[15:0], 16'h0000};
                opLw:    result = dmem[addr[7:2]];
                opSw: begin
                    wen = 1'b0;
                    dmem[addr[7:2]] = b;
                end
                opBeq: begin
                    wen = 1'b0;
                    if (a == b) target = nextPc + {imm[29:0], 2'b00};
                end
                opBne: begin
                    wen = 1'b0;
                    if (a != b) target = nextPc + {imm[29:0], 2'b00};
                end
                opJ: begin
                    wen = 1'b0;
                    target = {nextPc[31:28], instr[25:0], 2'b00};
                end
                default: wen = 1'b0;
            endcase
            if (wen && dst != '0) begin
                regs[dst] = result;
                expPc.push_back(pc);
                expNum.push_back(dst);
                expData.push_back(result);
            end
            pc     = nextPc;  // delay slot runs next
            nextPc = target;
            steps++;
        end
    endtask

    task automatic compareWrite();
        word_t    pcExp;
        regAddr_t numExp;
        word_t    dataExp;
        if (debugWbRfWen !== 4'hf) begin
            mismatches++;
            $display("FAILED debugWbRfWen: got %h, expected %h", debugWbRfWen, 4'hf);
        end
        if (expPc.size() == 0) begin
            extras++;
            $display("write to r%0d from pc %h came after the last expected write",
                     debugWbRfWnum, debugWbPc);
        end else begin
            pcExp   = expPc.pop_front();
            numExp  = expNum.pop_front();
            dataExp = expData.pop_front();
            if (debugWbPc !== pcExp) begin
                mismatches++;
                $display("FAILED debugWbPc: got %h, expected %h", debugWbPc, pcExp);
            end
            if (debugWbRfWnum !== numExp) begin
                mismatches++;
                $display("FAILED debugWbRfWnum: got %h, expected %h", debugWbRfWnum, numExp);
            end
            if (debugWbRfWdata !== dataExp) begin
                mismatches++;
                $display("FAILED debugWbRfWdata: got %h, expected %h (pc %h)",
                         debugWbRfWdata, dataExp, pcExp);
            end
        end
    endtask

    // debug port is steady at the falling edge
    always @(negedge clk) begin
        if (!rstN) begin
            done       = 1'b0;
            built      = 1'b0;
            mismatches = 0;
            extras     = 0;
        end else begin
            if (!built) begin
                buildModel();
                built = 1'b1;
            end
            if (dataCyc && dataSel !== 4'hf) begin  // word access uses all lanes
                mismatches++;
                $display("FAILED dataSel: got %h, expected %h", dataSel, 4'hf);
            end
            if (debugWbRfWen != 4'h0) begin
                compareWrite();
            end
            done = expPc.size() == 0;
        end
    end

endmodule

//--- source/cpuCore.sv
module cpuCore #(
    parameter corePkg::word_t resetPc = '0
) (
    input  logic              clk,
    input  logic              rstN,
    output corePkg::word_t    instAddr,
    input  corePkg::word_t    instData,
    output logic              dataCyc,
    output logic              dataStb,
    output logic              dataWe,
    output corePkg::word_t    dataAdr,
    output corePkg::word_t    dataDatW,
    output logic [3:0]        dataSel,
    input  corePkg::word_t    dataDatR,
    input  logic              dataAck,
    output corePkg::word_t    debugWbPc,
    output logic [3:0]        debugWbRfWen,
    output corePkg::regAddr_t debugWbRfWnum,
    output corePkg::word_t    debugWbRfWdata
);
    import corePkg::*;

    // hazard controls
    logic     stallF;
    logic     stallD;
    logic     bubbleE;
    logic     freeze;
    logic     busy;
    fwdSel_t  fwdA;
    fwdSel_t  fwdB;

    logic     redirect;
    word_t    redirectPc;
    word_t    pcD;
    word_t    instrD;
    regAddr_t rsD;
    regAddr_t rtD;

    word_t    pcE;
    word_t    rsValE;
    word_t    rtValE;
    word_t    immE;
    regAddr_t rsE;
    regAddr_t rtE;
    regAddr_t dstE;
    aluOp_t   aluOpE;
    logic     useImmE;
    logic     regWenE;
    logic     loadE;
    logic     storeE;
    logic     beqE;
    logic     bneE;
    logic     jumpE;
    logic [25:0] jumpIdxE;

    word_t    aluOutM;
    word_t    storeDataM;
    regAddr_t dstM;
    logic     regWenM;
    logic     loadM;
    logic     storeM;
    word_t    pcM;
    word_t    memResult;

    logic     wbWen;
    regAddr_t wbAddr;
    word_t    wbData;

    // every port name matches a wire above
    fetchStage #(.resetPc(resetPc)) i_fetch (.*);
    decodeStage i_decode (.*);
    executeStage i_execute (.*);
    memoryStage i_memory (.*);
    hazardUnit i_hazard (.*);

endmodule

//--- source/hazardUnit.sv
module hazardUnit (
    input  corePkg::regAddr_t rsD,
    input  corePkg::regAddr_t rtD,
    input  corePkg::regAddr_t rsE,
    input  corePkg::regAddr_t rtE,
    input  logic              loadE,
    input  corePkg::regAddr_t dstE,
    input  corePkg::regAddr_t dstM,
    input  logic              regWenE,
    input  logic              regWenM,
    input  corePkg::regAddr_t wbAddr,
    input  logic              wbWen,
    input  logic              busy,
    output logic              stallF,
    output logic              stallD,
    output logic              bubbleE,
    output logic              freeze,
    output corePkg::fwdSel_t  fwdA,
    output corePkg::fwdSel_t  fwdB
);
    import corePkg::*;

    logic loadUse;

    // newest producer wins
    function automatic fwdSel_t pickSource(regAddr_t src);
        if (src != '0 && regWenM && dstM == src) begin
            return fwdMem;
        end else if (src != '0 && wbWen && wbAddr == src) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    always_comb begin
        fwdA = pickSource(rsE);
        fwdB = pickSource(rtE);
    end

    assign loadUse = loadE && regWenE && dstE != '0 && (dstE == rsD || dstE == rtD);

    assign stallF  = loadUse;
    assign stallD  = loadUse;
    assign bubbleE = loadUse;
    assign freeze  = busy;  // whole pipeline waits for ack

endmodule

//--- source/memoryStage.sv
module memoryStage (
    input  logic              clk,
    input  logic              rstN,
    input  corePkg::word_t    aluOutM,
    input  corePkg::word_t    storeDataM,
    input  corePkg::regAddr_t dstM,
    input  logic              regWenM,
    input  logic              loadM,
    input  logic              storeM,
    input  corePkg::word_t    pcM,
    output logic              busy,
    output corePkg::word_t    memResult,
    output logic              dataCyc,
    output logic              dataStb,
    output logic              dataWe,
    output corePkg::word_t    dataAdr,
    output corePkg::word_t    dataDatW,
    output logic [3:0]        dataSel,
    input  corePkg::word_t    dataDatR,
    input  logic              dataAck,
    output logic              wbWen,
    output corePkg::regAddr_t wbAddr,
    output corePkg::word_t    wbData,
    output corePkg::word_t    debugWbPc,
    output logic [3:0]        debugWbRfWen,
    output corePkg::regAddr_t debugWbRfWnum,
    output corePkg::word_t    debugWbRfWdata
);
    import corePkg::*;

    busState_t state;
    busState_t stateNext;
    logic      memOp;
    logic      retire;

    assign memOp = loadM | storeM;

    always_comb begin
        stateNext = state;
        dataCyc   = 1'b0;
        case (state)
            busIdle: begin
                dataCyc = memOp;  // goes out in the first memory cycle
                if (memOp && !dataAck) begin
                    stateNext = busWaitAck;
                end
            end
            busWaitAck: begin
                dataCyc = 1'b1;
                if (dataAck) begin
                    stateNext = busIdle;
                end
            end
            default: stateNext = busIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= busIdle;
        end else begin
            state <= stateNext;
        end
    end

    assign dataStb   = dataCyc;
    assign dataWe    = storeM;
    assign dataAdr   = aluOutM;
    assign dataDatW  = storeDataM;
    assign dataSel   = 4'b1111;  // word access only
    assign busy      = dataCyc & ~dataAck;
    assign memResult = loadM ? dataDatR : aluOutM;

    // held while busy so writeback forwarding stays valid
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbWen  <= 1'b0;
            retire <= 1'b0;
        end else begin
            retire <= !busy && regWenM && dstM != '0;
            if (!busy) begin
                wbWen <= regWenM && dstM != '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            wbAddr    <= dstM;
            wbData    <= memResult;
            debugWbPc <= pcM;
        end
    end

    // one pulse per retiring write
    assign debugWbRfWen   = {4{retire}};
    assign debugWbRfWnum  = wbAddr;
    assign debugWbRfWdata = wbData;

endmodule

//--- source/executeStage.sv
module executeStage (
    input  logic              clk,
    input  logic              rstN,
    input  logic              freeze,
    input  corePkg::word_t    pcE,
    input  corePkg::word_t    rsValE,
    input  corePkg::word_t    rtValE,
    input  corePkg::word_t    immE,
    input  corePkg::regAddr_t dstE,
    input  corePkg::aluOp_t   aluOpE,
    input  logic              useImmE,
    input  logic              regWenE,
    input  logic              loadE,
    input  logic              storeE,
    input  logic              beqE,
    input  logic              bneE,
    input  logic              jumpE,
    input  logic [25:0]       jumpIdxE,
    input  corePkg::fwdSel_t  fwdA,
    input  corePkg::fwdSel_t  fwdB,
    input  corePkg::word_t    memResult,
    input  corePkg::word_t    wbData,
    output logic              redirect,
    output corePkg::word_t    redirectPc,
    output corePkg::word_t    aluOutM,
    output corePkg::word_t    storeDataM,
    output corePkg::regAddr_t dstM,
    output logic              regWenM,
    output logic              loadM,
    output logic              storeM,
    output corePkg::word_t    pcM
);
    import corePkg::*;

    word_t srcA;
    word_t rtFwd;
    word_t srcB;
    word_t aluOut;
    word_t pcPlus4;
    word_t branchTarget;
    word_t jumpTarget;
    logic  taken;

    function automatic word_t pickOperand(fwdSel_t sel, word_t regVal, word_t memVal,
                                          word_t wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA  = pickOperand(fwdA, rsValE, memResult, wbData);
    assign rtFwd = pickOperand(fwdB, rtValE, memResult, wbData);  // also the store data
    assign srcB  = useImmE ? immE : rtFwd;

    always_comb begin
        case (aluOpE)
            aluSub:  aluOut = srcA - srcB;
            aluAnd:  aluOut = srcA & srcB;
            aluOr:   aluOut = srcA | srcB;
            aluXor:  aluOut = srcA ^ srcB;
            aluSlt:  aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
            aluLui:  aluOut = {srcB[15:0], 16'h0000};
            default: aluOut = srcA + srcB;
        endcase
    end

    // targets relative to the delay slot
    assign pcPlus4      = pcE + 32'd4;
    assign branchTarget = pcPlus4 + {immE[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], jumpIdxE, 2'b00};
    assign taken        = (beqE && srcA == rtFwd) || (bneE && srcA != rtFwd);
    assign redirect     = taken || jumpE;
    assign redirectPc   = jumpE ? jumpTarget : branchTarget;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWenM <= 1'b0;
            loadM   <= 1'b0;
            storeM  <= 1'b0;
        end else if (!freeze) begin
            regWenM <= regWenE;
            loadM   <= loadE;
            storeM  <= storeE;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            aluOutM    <= aluOut;
            storeDataM <= rtFwd;
            dstM       <= dstE;
            pcM        <= pcE;
        end
    end

endmodule

//--- source/decodeStage.sv
module decodeStage (
    input  logic              clk,
    input  logic              rstN,
    input  corePkg::word_t    pcD,
    input  corePkg::word_t    instrD,
    input  logic              bubbleE,
    input  logic              freeze,
    input  logic              wbWen,
    input  corePkg::regAddr_t wbAddr,
    input  corePkg::word_t    wbData,
    output corePkg::regAddr_t rsD,
    output corePkg::regAddr_t rtD,
    output corePkg::word_t    pcE,
    output corePkg::word_t    rsValE,
    output corePkg::word_t    rtValE,
    output corePkg::word_t    immE,
    output corePkg::regAddr_t rsE,
    output corePkg::regAddr_t rtE,
    output corePkg::regAddr_t dstE,
    output corePkg::aluOp_t   aluOpE,
    output logic              useImmE,
    output logic              regWenE,
    output logic              loadE,
    output logic              storeE,
    output logic              beqE,
    output logic              bneE,
    output logic              jumpE,
    output logic [25:0]       jumpIdxE
);
    import corePkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr_t   rdD;
    regAddr_t   dst;
    aluOp_t     aluOp;
    word_t      immD;
    word_t      rsVal;
    word_t      rtVal;
    logic       signExt;
    logic       useImm;
    logic       regWen;
    logic       load;
    logic       store;
    logic       beq;
    logic       bne;
    logic       jump;

    assign opcode = instrD[31:26];
    assign funct  = instrD[5:0];
    assign rsD    = instrD[25:21];
    assign rtD    = instrD[20:16];
    assign rdD    = instrD[15:11];

    always_comb begin
        aluOp   = aluAdd;
        dst     = rtD;  // i-type writes rt
        signExt = 1'b1;
        useImm  = 1'b0;
        regWen  = 1'b0;
        load    = 1'b0;
        store   = 1'b0;
        beq     = 1'b0;
        bne     = 1'b0;
        jump    = 1'b0;
        case (opcode)
            opSpecial: begin
                dst    = rdD;
                regWen = 1'b1;
                case (funct)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnSlt:   aluOp = aluSlt;
                    default: regWen = 1'b0;  // nop and anything unknown
                endcase
            end
            opAddiu: begin
                useImm = 1'b1;
                regWen = 1'b1;
            end
            opOri: begin
                aluOp   = aluOr;
                signExt = 1'b0;
                useImm  = 1'b1;
                regWen  = 1'b1;
            end
            opLui: begin
                aluOp  = aluLui;
                useImm = 1'b1;
                regWen = 1'b1;
            end
            opLw: begin
                useImm = 1'b1;
                regWen = 1'b1;
                load   = 1'b1;
            end
            opSw: begin
                useImm = 1'b1;
                store  = 1'b1;
            end
            opBeq:   beq = 1'b1;
            opBne:   bne = 1'b1;
            opJ:     jump = 1'b1;
            default: ;
        endcase
    end

    assign immD = signExt ? {{16{instrD[15]}}, instrD[15:0]} : {16'h0000, instrD[15:0]};

    regFile i_regFile (
        .clk  (clk),
        .rstN (rstN),
        .raA  (rsD),
        .raB  (rtD),
        .wa   (wbAddr),
        .we   (wbWen),
        .wd   (wbData),
        .rdA  (rsVal),
        .rdB  (rtVal)
    );

    // control bits, cleared for a bubble
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWenE <= 1'b0;
            loadE   <= 1'b0;
            storeE  <= 1'b0;
            beqE    <= 1'b0;
            bneE    <= 1'b0;
            jumpE   <= 1'b0;
        end else if (!freeze) begin
            regWenE <= regWen & ~bubbleE;
            loadE   <= load & ~bubbleE;
            storeE  <= store & ~bubbleE;
            beqE    <= beq & ~bubbleE;
            bneE    <= bne & ~bubbleE;
            jumpE   <= jump & ~bubbleE;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            pcE      <= pcD;
            rsValE   <= rsVal;
            rtValE   <= rtVal;
            immE     <= immD;
            rsE      <= rsD;
            rtE      <= rtD;
            dstE     <= dst;
            aluOpE   <= aluOp;
            useImmE  <= useImm;
            jumpIdxE <= instrD[25:0];
        end
    end

endmodule

//--- source/fetchStage.sv
module fetchStage #(
    parameter corePkg::word_t resetPc = '0
) (
    input  logic           clk,
    input  logic           rstN,
    input  logic           stallF,
    input  logic           stallD,
    input  logic           freeze,
    input  logic           redirect,
    input  corePkg::word_t redirectPc,
    input  corePkg::word_t instData,
    output corePkg::word_t instAddr,
    output corePkg::word_t pcD,
    output corePkg::word_t instrD
);
    import corePkg::*;

    word_t pc;
    word_t pcNext;

    assign pcNext   = redirect ? redirectPc : pc + 32'd4;
    assign instAddr = pc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (!freeze && !stallF) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            instrD <= nopWord;
        end else if (!freeze) begin
            if (redirect) begin
                instrD <= nopWord;  // fetched past the delay slot
            end else if (!stallD) begin
                instrD <= instData;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze && !stallD) begin
            pcD <= pc;
        end
    end

endmodule

//--- source/regFile.sv
module regFile (
    input  logic              clk,
    input  logic              rstN,
    input  corePkg::regAddr_t raA,
    input  corePkg::regAddr_t raB,
    input  corePkg::regAddr_t wa,
    input  logic              we,
    input  corePkg::word_t    wd,
    output corePkg::word_t    rdA,
    output corePkg::word_t    rdB
);
    import corePkg::*;

    word_t regs [32];

    // r0 reads zero, writeback bypasses the array
    function automatic word_t readPort(regAddr_t ra);
        if (ra == '0) begin
            return '0;
        end else if (we && wa == ra) begin
            return wd;
        end
        return regs[ra];
    endfunction

    always_ff @(posedge clk) begin
        if (rstN && we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rdA = readPort(raA);
        rdB = readPort(raB);
    end

endmodule

//--- source/corePkg.sv
package corePkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [1:0]  fwdSel_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluLui
    } aluOp_t;

    // data side wishbone cycle
    typedef enum logic {
        busIdle,
        busWaitAck
    } busState_t;

    localparam fwdSel_t fwdReg = 2'd0;  // value read in decode
    localparam fwdSel_t fwdMem = 2'd1;
    localparam fwdSel_t fwdWb  = 2'd2;

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // funct field of special
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;

    localparam word_t nopWord = 32'h0000_0000;  // sll r0, r0, 0

endpackage
